// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 -f verilog.f --top-module gpu_main_tb \
		-Mdir obj_dir -o gpu_main_tb
	./obj_dir/gpu_main_tb

clean:
	rm -rf obj_dir

// ==== src/gpu_core.sv ====
`timescale 1ns/1ps

module gpu_core (
    input  logic               clock,
    input  logic               rst_n,

    input  gpu_pkg::word_t     h2f_value,
    output gpu_pkg::word_t     f2h_value,

    output gpu_pkg::core_bus_t bus,
    input  logic               sdram_waitrequest,
    input  gpu_pkg::word_t     sdram_readdata,
    input  logic               sdram_readdatavalid,

    output logic               mem_request,
    input  logic               mem_authorized
);

    gpu_pkg::gpu_cmd_t    host_cmd;
    gpu_pkg::gpu_cmd_t    cmd_q;
    gpu_pkg::core_state_e state;
    gpu_pkg::count_t      issued;
    gpu_pkg::count_t      returned;
    gpu_pkg::count_t      last_index;
    gpu_pkg::result_t     result_q;
    gpu_pkg::result_t     sum_next;
    gpu_pkg::gpu_status_t status;
    gpu_pkg::sdram_addr_t byte_address;
    gpu_pkg::word_t       fill_word;
    logic                 drive_bus;
    logic                 accepted;
    logic                 read_return;

    function automatic logic op_active(gpu_pkg::gpu_op_t op);
        return (op == gpu_pkg::OP_FILL) || (op == gpu_pkg::OP_SUM);
    endfunction

    assign host_cmd = h2f_value;

    // command is captured while idle and stays put for the whole run
    always_ff @(posedge clock) begin
        if (state == gpu_pkg::CORE_IDLE) begin
            cmd_q <= host_cmd;
        end
    end

    // port is held from the request until the last read has come back
    assign mem_request = (state == gpu_pkg::CORE_REQUEST) ||
                         (state == gpu_pkg::CORE_WRITE) ||
                         (state == gpu_pkg::CORE_READ) ||
                         (state == gpu_pkg::CORE_DRAIN);

    assign drive_bus = mem_authorized &&
                       ((state == gpu_pkg::CORE_WRITE) || (state == gpu_pkg::CORE_READ));

    // transfer taken on the first edge without waitrequest
    assign accepted = drive_bus && !sdram_waitrequest;

    // returns only belong to us while reads are outstanding
    assign read_return = sdram_readdatavalid &&
                         ((state == gpu_pkg::CORE_READ) || (state == gpu_pkg::CORE_DRAIN)) &&
                         (returned != issued);

    assign last_index = gpu_pkg::count_t'(cmd_q.count - 1'b1);

    // word address base + index, then to bytes
    assign byte_address = (gpu_pkg::sdram_addr_t'(cmd_q.base) +
                           gpu_pkg::sdram_addr_t'(issued)) << 2;

    // seed in every byte plus the word index
    assign fill_word = {4{cmd_q.seed}} + gpu_pkg::word_t'(issued);

    assign sum_next = result_q + sdram_readdata[23:0];

    always_comb begin
        bus = '0;
        if (drive_bus) begin
            bus.address = byte_address;
            bus.read    = (state == gpu_pkg::CORE_READ);
            bus.write   = (state == gpu_pkg::CORE_WRITE);
            if (state == gpu_pkg::CORE_WRITE) begin
                bus.writedata = fill_word;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= gpu_pkg::CORE_IDLE;
            issued   <= '0;
            returned <= '0;
            result_q <= '0;
        end else begin
            case (state)
                gpu_pkg::CORE_IDLE: begin
                    issued   <= '0;
                    returned <= '0;
                    result_q <= '0;
                    if (op_active(host_cmd.op)) begin
                        // empty run needs no port at all
                        if (host_cmd.count == '0) begin
                            state <= gpu_pkg::CORE_DONE;
                        end else begin
                            state <= gpu_pkg::CORE_REQUEST;
                        end
                    end
                end

                gpu_pkg::CORE_REQUEST: begin
                    if (mem_authorized) begin
                        if (cmd_q.op == gpu_pkg::OP_FILL) begin
                            state <= gpu_pkg::CORE_WRITE;
                        end else begin
                            state <= gpu_pkg::CORE_READ;
                        end
                    end
                end

                gpu_pkg::CORE_WRITE: begin
                    if (accepted) begin
                        issued   <= issued + 1'b1;
                        // fill result ends up equal to the count
                        result_q <= result_q + 1'b1;
                        if (issued == last_index) begin
                            state <= gpu_pkg::CORE_DONE;
                        end
                    end
                end

                gpu_pkg::CORE_READ: begin
                    if (accepted) begin
                        issued <= issued + 1'b1;
                        if (issued == last_index) begin
                            state <= gpu_pkg::CORE_DRAIN;
                        end
                    end
                    if (read_return) begin
                        returned <= returned + 1'b1;
                        result_q <= sum_next;
                    end
                end

                gpu_pkg::CORE_DRAIN: begin
                    // all reads issued, wait for the rest of the data
                    if (read_return) begin
                        returned <= returned + 1'b1;
                        result_q <= sum_next;
                        if (returned == last_index) begin
                            state <= gpu_pkg::CORE_DONE;
                        end
                    end
                end

                gpu_pkg::CORE_DONE: begin
                    // result held until the host drops the command
                    if (!op_active(host_cmd.op)) begin
                        result_q <= '0;
                        state    <= gpu_pkg::CORE_IDLE;
                    end
                end

                default: begin
                    state <= gpu_pkg::CORE_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        status        = '0;
        status.done   = (state == gpu_pkg::CORE_DONE);
        status.busy   = mem_request;
        status.result = result_q;
    end

    assign f2h_value = status;

endmodule

// ==== src/gpu_main.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module gpu_main (
    input  logic           clock,
    input  logic           rst_n,

    input  gpu_pkg::word_t h2f_value [0:`GPU_CORE_COUNT-1],
    output gpu_pkg::word_t f2h_value [0:`GPU_CORE_COUNT-1],

    output logic [29:0]    sdram_address,
    input  logic           sdram_waitrequest,
    input  gpu_pkg::word_t sdram_readdata,
    input  logic           sdram_readdatavalid,
    output logic           sdram_read,
    output gpu_pkg::word_t sdram_writedata,
    output logic           sdram_write
);

    localparam int CORE_COUNT = `GPU_CORE_COUNT;

    gpu_pkg::core_bus_t    core_bus [0:CORE_COUNT-1];
    gpu_pkg::core_bus_t    merged_bus;
    logic [CORE_COUNT-1:0] mem_request;
    logic [CORE_COUNT-1:0] mem_authorized;

    for (genvar core = 0; core < CORE_COUNT; core++) begin : g_core
        gpu_core u_core (
            .clock               (clock),
            .rst_n               (rst_n),

            .h2f_value           (h2f_value[core]),
            .f2h_value           (f2h_value[core]),

            .bus                 (core_bus[core]),
            .sdram_waitrequest   (sdram_waitrequest),
            .sdram_readdata      (sdram_readdata),
            .sdram_readdatavalid (sdram_readdatavalid),

            .mem_request         (mem_request[core]),
            .mem_authorized      (mem_authorized[core])
        );
    end

    // one grant at a time, so or-ing the zeroed buses picks the owner
    always_comb begin
        merged_bus = '0;
        for (int core = 0; core < CORE_COUNT; core++) begin
            merged_bus.address   = merged_bus.address | core_bus[core].address;
            merged_bus.read      = merged_bus.read | core_bus[core].read;
            merged_bus.write     = merged_bus.write | core_bus[core].write;
            merged_bus.writedata = merged_bus.writedata | core_bus[core].writedata;
        end
    end

    assign sdram_read      = merged_bus.read;
    assign sdram_write     = merged_bus.write;
    assign sdram_writedata = merged_bus.writedata;

    // move into the core region, then byte to word address
    assign sdram_address = (30'(merged_bus.address) + `GPU_SDRAM_OFFSET) >> 2;

    mem_arb #(
        .COUNT (CORE_COUNT)
    ) u_mem_arb (
        .clock      (clock),
        .rst_n      (rst_n),
        .request    (mem_request),
        .authorized (mem_authorized)
    );

endmodule

// ==== src/gpu_params.svh ====
`ifndef GPU_PARAMS_SVH
`define GPU_PARAMS_SVH

// number of cores sharing the SDRAM port
`define GPU_CORE_COUNT 4

// data word on the SDRAM bus and in the host registers
`define GPU_WORD_WIDTH 32

// word address as the host gives it
`define GPU_ADDRESS_WIDTH 16

// byte address driven by a core onto the merged bus
`define GPU_SDRAM_ADDRESS_WIDTH 24

// byte offset of the core region inside SDRAM
`define GPU_SDRAM_OFFSET 30'h3E000000

`endif

// ==== src/gpu_pkg.sv ====
`include "gpu_params.svh"

package gpu_pkg;

    typedef logic [`GPU_WORD_WIDTH-1:0]          word_t;
    typedef logic [`GPU_ADDRESS_WIDTH-1:0]       core_addr_t;
    typedef logic [`GPU_SDRAM_ADDRESS_WIDTH-1:0] sdram_addr_t;

    // word count of one command, 0 means nothing to do
    typedef logic [5:0]  count_t;
    typedef logic [7:0]  seed_t;
    typedef logic [23:0] result_t;

    // host op codes, 3 behaves like idle
    typedef logic [1:0] gpu_op_t;
    localparam gpu_op_t OP_IDLE = 2'd0;
    localparam gpu_op_t OP_FILL = 2'd1;
    localparam gpu_op_t OP_SUM  = 2'd2;

    // overlaid on h2f_value
    typedef struct packed {
        gpu_op_t    op;
        count_t     count;
        core_addr_t base;
        seed_t      seed;
    } gpu_cmd_t;

    // overlaid on f2h_value
    typedef struct packed {
        logic       done;
        logic       busy;
        logic [5:0] reserved;
        result_t    result;
    } gpu_status_t;

    // one core's request to the shared port, all zero when not granted
    typedef struct packed {
        sdram_addr_t address;
        logic        read;
        logic        write;
        word_t       writedata;
    } core_bus_t;

    typedef enum logic [2:0] {
        CORE_IDLE,
        CORE_REQUEST,
        CORE_WRITE,
        CORE_READ,
        CORE_DRAIN,
        CORE_DONE
    } core_state_e;

endpackage

// ==== src/mem_arb.sv ====
`timescale 1ns/1ps

module mem_arb #(
    parameter int COUNT = 4
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [COUNT-1:0] request,
    output logic [COUNT-1:0] authorized
);

    localparam int PTR_W = (COUNT > 1) ? $clog2(COUNT) : 1;

    logic [PTR_W-1:0] last_winner;
    logic [PTR_W-1:0] next_winner;
    logic             next_found;
    logic             holding;

    // owner keeps the port as long as its request stays up
    assign holding = |(authorized & request);

    // round-robin search, starting just after the last winner
    always_comb begin
        int idx;
        next_winner = last_winner;
        next_found  = 1'b0;
        for (int i = 1; i <= COUNT; i++) begin
            idx = (int'(last_winner) + i) % COUNT;
            if (!next_found && request[idx]) begin
                next_winner = PTR_W'(idx);
                next_found  = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            authorized  <= '0;
            // so that core 0 is searched first
            last_winner <= PTR_W'(COUNT - 1);
        end else if (!holding) begin
            // released or free, hand over in the same edge if someone waits
            authorized <= '0;
            if (next_found) begin
                authorized[next_winner] <= 1'b1;
                last_winner             <= next_winner;
            end
        end
    end

endmodule

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clock
);

    // free running, starts low
    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clock = ~clock;
        end
    end

endmodule

// ==== test/gpu_main_tb.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module gpu_main_tb;

    localparam int CORES         = `GPU_CORE_COUNT;
    localparam int ROWS          = 7;
    localparam int MAX_COUNT     = 20;
    localparam int WORST_LATENCY = 16;
    localparam int CYCLE_LIMIT   = ROWS * MAX_COUNT * CORES * WORST_LATENCY;
    localparam int INDEX_WIDTH   = 12;
    localparam int DEPTH         = 1 << INDEX_WIDTH;

    logic           clock;
    logic           rst_n;
    logic           random_timing;
    gpu_pkg::word_t h2f_value [0:CORES-1];
    gpu_pkg::word_t f2h_value [0:CORES-1];
    logic [29:0]    sdram_address;
    logic           sdram_waitrequest;
    gpu_pkg::word_t sdram_readdata;
    logic           sdram_readdatavalid;
    logic           sdram_read;
    gpu_pkg::word_t sdram_writedata;
    logic           sdram_write;

    // command table, one entry per row and core
    string                row_name   [0:ROWS-1];
    gpu_pkg::word_t       row_cmd    [0:ROWS-1][0:CORES-1];
    gpu_pkg::gpu_status_t row_expect [0:ROWS-1][0:CORES-1];
    logic                 row_random [0:ROWS-1];
    int                   cycle = 0;

    clock_gen #(.PERIOD_NS(8)) u_clock (.clock(clock));

    gpu_main DUT (
        .clock               (clock),
        .rst_n               (rst_n),
        .h2f_value           (h2f_value),
        .f2h_value           (f2h_value),
        .sdram_address       (sdram_address),
        .sdram_waitrequest   (sdram_waitrequest),
        .sdram_readdata      (sdram_readdata),
        .sdram_readdatavalid (sdram_readdatavalid),
        .sdram_read          (sdram_read),
        .sdram_writedata     (sdram_writedata),
        .sdram_write         (sdram_write)
    );

    sdram_model #(.INDEX_WIDTH(INDEX_WIDTH)) u_sdram (
        .clock         (clock),
        .rst_n         (rst_n),
        .random_timing (random_timing),
        .address       (sdram_address),
        .read          (sdram_read),
        .write         (sdram_write),
        .writedata     (sdram_writedata),
        .waitrequest   (sdram_waitrequest),
        .readdata      (sdram_readdata),
        .readdatavalid (sdram_readdatavalid)
    );

    function automatic gpu_pkg::word_t make_cmd(gpu_pkg::gpu_op_t op, int count, int base,
                                                int seed);
        gpu_pkg::gpu_cmd_t cmd;
        cmd.op    = op;
        cmd.count = gpu_pkg::count_t'(count);
        cmd.base  = gpu_pkg::core_addr_t'(base);
        cmd.seed  = gpu_pkg::seed_t'(seed);
        return cmd;
    endfunction

    // seed in all four bytes, plus the word index
    function automatic gpu_pkg::word_t pattern_word(gpu_pkg::seed_t seed, int index);
        return {4{seed}} + gpu_pkg::word_t'(index);
    endfunction

    function automatic gpu_pkg::result_t sum_of_pattern(int seed, int count);
        gpu_pkg::word_t acc;
        acc = '0;
        for (int i = 0; i < count; i++) begin
            acc = acc + pattern_word(gpu_pkg::seed_t'(seed), i);
        end
        return acc[23:0];
    endfunction

    function automatic gpu_pkg::gpu_status_t done_status(gpu_pkg::result_t result);
        gpu_pkg::gpu_status_t status;
        status        = '0;
        status.done   = 1'b1;
        status.result = result;
        return status;
    endfunction

    function automatic logic is_commanded(gpu_pkg::word_t value);
        gpu_pkg::gpu_cmd_t cmd;
        cmd = value;
        return (cmd.op == gpu_pkg::OP_FILL) || (cmd.op == gpu_pkg::OP_SUM);
    endfunction

    // one cycle into a command the core is busy, or already done for an empty run
    function automatic gpu_pkg::gpu_status_t start_status(gpu_pkg::word_t value);
        gpu_pkg::gpu_cmd_t    cmd;
        gpu_pkg::gpu_status_t status;
        cmd    = value;
        status = '0;
        if (is_commanded(value)) begin
            if (cmd.count == '0) begin
                status.done = 1'b1;
            end else begin
                status.busy = 1'b1;
            end
        end
        return status;
    endfunction

    task automatic clear_row(int r, string name, logic rnd);
        row_name[r]   = name;
        row_random[r] = rnd;
        for (int c = 0; c < CORES; c++) begin
            row_cmd[r][c]    = '0;
            row_expect[r][c] = '0;
        end
    endtask

    task automatic put_fill(int r, int c, int count, int base, int seed);
        row_cmd[r][c]    = make_cmd(gpu_pkg::OP_FILL, count, base, seed);
        row_expect[r][c] = done_status(gpu_pkg::result_t'(count));
    endtask

    // seed is the one the earlier fill of this region used
    task automatic put_sum(int r, int c, int count, int base, int seed);
        row_cmd[r][c]    = make_cmd(gpu_pkg::OP_SUM, count, base, 0);
        row_expect[r][c] = done_status(sum_of_pattern(seed, count));
    endtask

    task automatic build_table();
        clear_row(0, "fill_one", 1'b0);
        put_fill(0, 0, 10, 'h100, 'h11);
        clear_row(1, "sum_one", 1'b0);
        put_sum(1, 0, 10, 'h100, 'h11);
        clear_row(2, "fill_all", 1'b0);
        clear_row(3, "sum_all", 1'b0);
        clear_row(4, "fill_all_random", 1'b1);
        clear_row(5, "sum_all_random", 1'b1);
        for (int c = 0; c < CORES; c++) begin
            put_fill(2, c, 16, 'h200 + c * 'h40, 'h21 + c * 'h11);
            put_sum(3, c, 16, 'h200 + c * 'h40, 'h21 + c * 'h11);
            put_fill(4, c, MAX_COUNT, 'h400 + c * 'h40, 'h65 + c * 'h11);
            put_sum(5, c, MAX_COUNT, 'h400 + c * 'h40, 'h65 + c * 'h11);
        end
        clear_row(6, "count_zero", 1'b0);
        put_fill(6, 1, 0, 'h700, 'h5a);
        put_sum(6, 2, 0, 'h700, 0);
    endtask

    task automatic compare_status(string name, gpu_pkg::gpu_status_t expected,
                                  gpu_pkg::gpu_status_t actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic compare_word(string name, gpu_pkg::word_t expected,
                                gpu_pkg::word_t actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    // every filled word sits at offset + base + index in the model
    task automatic check_memory(int r);
        gpu_pkg::gpu_cmd_t cmd;
        int                idx;
        for (int c = 0; c < CORES; c++) begin
            cmd = row_cmd[r][c];
            if (cmd.op == gpu_pkg::OP_FILL) begin
                for (int i = 0; i < int'(cmd.count); i++) begin
                    idx = (int'(`GPU_SDRAM_OFFSET >> 2) + int'(cmd.base) + i) % DEPTH;
                    compare_word($sformatf("%s core %0d word %0d", row_name[r], c, i),
                                 pattern_word(cmd.seed, i), u_sdram.mem[idx]);
                end
            end
        end
    endtask

    function automatic logic all_done(int r);
        gpu_pkg::gpu_status_t status;
        for (int c = 0; c < CORES; c++) begin
            status = f2h_value[c];
            if (is_commanded(row_cmd[r][c]) && !status.done) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic logic all_clear();
        gpu_pkg::gpu_status_t status;
        for (int c = 0; c < CORES; c++) begin
            status = f2h_value[c];
            if (status.done) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // run limit from rows, longest count, cores and worst latency
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT never finished a row", cycle);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst_n         <= 1'b0;
        random_timing <= 1'b0;
        for (int c = 0; c < CORES; c++) begin
            h2f_value[c] <= '0;
        end
        build_table();
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;

        @(negedge clock);
        compare_word("reset_bus", '0, gpu_pkg::word_t'({sdram_read, sdram_write}));
        for (int c = 0; c < CORES; c++) begin
            compare_status($sformatf("reset core %0d", c), '0, f2h_value[c]);
        end

        for (int r = 0; r < ROWS; r++) begin
            @(posedge clock);
            random_timing <= row_random[r];
            for (int c = 0; c < CORES; c++) begin
                h2f_value[c] <= row_cmd[r][c];
            end

            // cores pick the command up on the following edge
            @(posedge clock);
            @(negedge clock);
            for (int c = 0; c < CORES; c++) begin
                compare_status($sformatf("%s core %0d start", row_name[r], c),
                               start_status(row_cmd[r][c]), f2h_value[c]);
            end

            do @(negedge clock); while (!all_done(r));
            for (int c = 0; c < CORES; c++) begin
                compare_status($sformatf("%s core %0d", row_name[r], c),
                               row_expect[r][c], f2h_value[c]);
            end
            check_memory(r);

            // results must stay while the command is still up
            repeat (4) @(negedge clock);
            for (int c = 0; c < CORES; c++) begin
                compare_status($sformatf("%s core %0d held", row_name[r], c),
                               row_expect[r][c], f2h_value[c]);
            end

            @(posedge clock);
            for (int c = 0; c < CORES; c++) begin
                h2f_value[c] <= '0;
            end
            do @(negedge clock); while (!all_clear());
            for (int c = 0; c < CORES; c++) begin
                compare_status($sformatf("%s core %0d idle", row_name[r], c),
                               '0, f2h_value[c]);
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== test/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model #(
    parameter int INDEX_WIDTH = 12
) (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           random_timing,
    input  logic [29:0]    address,
    input  logic           read,
    input  logic           write,
    input  gpu_pkg::word_t writedata,
    output logic           waitrequest,
    output gpu_pkg::word_t readdata,
    output logic           readdatavalid
);

    localparam int DEPTH         = 1 << INDEX_WIDTH;
    localparam int FIXED_LATENCY = 2;

    gpu_pkg::word_t mem [0:DEPTH-1];
    gpu_pkg::word_t pending_data [$];
    int             pending_due [$];
    int             seed     = 32'h3fe1;
    int             now      = 0;
    int             last_due = 0;
    logic           wait_q   = 1'b0;
    logic           valid_q  = 1'b0;
    gpu_pkg::word_t data_q   = '0;

    assign waitrequest   = wait_q;
    assign readdatavalid = valid_q;
    assign readdata      = data_q;

    // background content, different at every address
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'hc0de0000 ^ (32'(i) * 32'h00019e37);
        end
    end

    always @(posedge clock) begin
        int lat;
        int due;
        if (!rst_n) begin
            wait_q  <= 1'b0;
            valid_q <= 1'b0;
            data_q  <= '0;
            pending_data.delete();
            pending_due.delete();
            last_due = now;
        end else begin
            // oldest pending read goes out first, one per cycle
            valid_q <= 1'b0;
            if (pending_due.size() > 0 && pending_due[0] <= now) begin
                data_q  <= pending_data.pop_front();
                valid_q <= 1'b1;
                void'(pending_due.pop_front());
            end

            // transfer taken when waitrequest was low on this edge
            if ((read || write) && !wait_q) begin
                if (write) begin
                    mem[address[INDEX_WIDTH-1:0]] = writedata;
                end else begin
                    if (random_timing) begin
                        lat = 1 + int'($random(seed) & 7);
                    end else begin
                        lat = FIXED_LATENCY;
                    end
                    due = now + lat;
                    // keep returns in order
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    pending_data.push_back(mem[address[INDEX_WIDTH-1:0]]);
                    pending_due.push_back(due);
                end
            end

            if (random_timing) begin
                wait_q <= (($random(seed) & 1) != 0);
            end else begin
                wait_q <= 1'b0;
            end
        end
        now = now + 1;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/gpu_pkg.sv
src/mem_arb.sv
src/gpu_core.sv
src/gpu_main.sv
test/clock_gen.sv
test/sdram_model.sv
test/gpu_main_tb.sv
